// ==== gat_pkg.sv ====
package gat_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int NUM_FEAT   = 16;
  localparam int DATA_W     = 8;
  localparam int WH_W       = 12;
  localparam int PROD_W     = WH_W + DATA_W;
  localparam int ACC_W      = 24;
  localparam int SHIFT_W    = 5;
  localparam int CFG_ADDR_W = 6;

  // Levels of the adder tree and index into one weight half
  localparam int TREE_LVLS  = $clog2(NUM_FEAT);
  localparam int FEAT_IDX_W = $clog2(NUM_FEAT);

  // ==============================
  // Configuration address map
  // ==============================
  localparam logic [CFG_ADDR_W-1:0] CFG_A_SRC_BASE = CFG_ADDR_W'(0);
  localparam logic [CFG_ADDR_W-1:0] CFG_A_NBR_BASE = CFG_ADDR_W'(16);
  localparam logic [CFG_ADDR_W-1:0] CFG_SHIFT_ADDR = CFG_ADDR_W'(32);

  // ==============================
  // Element types
  // ==============================
  typedef logic signed [WH_W-1:0]   wh_elem_t;
  typedef logic signed [DATA_W-1:0] weight_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Transformed feature vector of one node
  typedef struct packed {
    wh_elem_t [NUM_FEAT-1:0] feat;
    logic                    src_flag;
  } wh_word_t;

  // Attention vector halves plus the output scaling
  typedef struct packed {
    weight_t [NUM_FEAT-1:0] a_src;
    weight_t [NUM_FEAT-1:0] a_nbr;
    logic [SHIFT_W-1:0]     shift;
  } attn_weights_t;

  typedef struct packed {
    logic              is_src;
    logic [DATA_W-1:0] value;
  } coef_word_t;

endpackage

// ==== attn_weight_regs.sv ====
`timescale 1ns/100ps

module attn_weight_regs (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cfg_we_i,
  input  logic [gat_pkg::CFG_ADDR_W-1:0]    cfg_addr_i,
  input  logic [gat_pkg::DATA_W-1:0]        cfg_wdata_i,
  output gat_pkg::attn_weights_t            weights_o
);

  localparam int AW = gat_pkg::CFG_ADDR_W;
  localparam int IW = gat_pkg::FEAT_IDX_W;

  // Offsets into each half, wrap to large values below the base
  logic [AW-1:0] src_off;
  logic [AW-1:0] nbr_off;
  logic          hit_src;
  logic          hit_nbr;
  logic          hit_shift;

  gat_pkg::attn_weights_t weights_q;

  // ==============================
  // Address decode
  // ==============================
  assign src_off = cfg_addr_i - gat_pkg::CFG_A_SRC_BASE;
  assign nbr_off = cfg_addr_i - gat_pkg::CFG_A_NBR_BASE;

  assign hit_src   = src_off < AW'(gat_pkg::NUM_FEAT);
  assign hit_nbr   = nbr_off < AW'(gat_pkg::NUM_FEAT);
  assign hit_shift = cfg_addr_i == gat_pkg::CFG_SHIFT_ADDR;

  // ==============================
  // Register file
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weights_q <= '0;
    end else if (cfg_we_i) begin
      if (hit_src) begin
        weights_q.a_src[src_off[IW-1:0]] <= cfg_wdata_i;
      end else if (hit_nbr) begin
        weights_q.a_nbr[nbr_off[IW-1:0]] <= cfg_wdata_i;
      end else if (hit_shift) begin
        // Only the low bits make sense as a shift count
        weights_q.shift <= cfg_wdata_i[gat_pkg::SHIFT_W-1:0];
      end
    end
  end

  assign weights_o = weights_q;

endmodule

// ==== attn_score_pipe.sv ====
`timescale 1ns/100ps

module attn_score_pipe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wh_vld_i,
  input  gat_pkg::wh_word_t      wh_i,
  input  gat_pkg::attn_weights_t weights_i,
  output logic                   coef_wr_o,
  output gat_pkg::coef_word_t    coef_o
);

  localparam int LVLS  = gat_pkg::TREE_LVLS;
  localparam int DW    = gat_pkg::DATA_W;
  localparam int SUM_W = gat_pkg::ACC_W + 1;

  localparam logic signed [SUM_W-1:0] COEF_MAX = SUM_W'((1 << (DW - 1)) - 1);

  // Side-band that travels with each word through the tree
  logic [LVLS:0]                        vld_q;
  logic [LVLS:0]                        flag_q;
  logic [LVLS:0][gat_pkg::SHIFT_W-1:0]  shift_q;

  gat_pkg::acc_t           src_score_q;
  gat_pkg::acc_t           src_sel;
  logic signed [SUM_W-1:0] total;
  logic signed [SUM_W-1:0] total_q;
  logic                    comb_vld_q;
  logic                    comb_src_q;
  logic [DW-1:0]           coef_val;
  logic                    coef_wr_q;
  gat_pkg::coef_word_t     coef_q;

  // ==============================
  // Side-band shift chain
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q   <= '0;
      flag_q  <= '0;
      shift_q <= '0;
    end else begin
      vld_q   <= {vld_q[LVLS-1:0], wh_vld_i};
      // Flag only counts for a real word
      flag_q  <= {flag_q[LVLS-1:0], wh_vld_i & wh_i.src_flag};
      // Shift is captured with the word, later rewrites do not touch it
      shift_q <= {shift_q[LVLS-1:0], weights_i.shift};
    end
  end

  // ==============================
  // Products and adder tree
  // ==============================
  for (genvar lvl = 0; lvl <= LVLS; lvl++) begin : g_lvl
    localparam int N = gat_pkg::NUM_FEAT >> lvl;

    gat_pkg::acc_t src_q [N];
    gat_pkg::acc_t nbr_q [N];

    if (lvl == 0) begin : g_prod
      // Edge 0, one product per element for each half
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int k = 0; k < N; k++) begin
            src_q[k] <= '0;
            nbr_q[k] <= '0;
          end
        end else begin
          for (int k = 0; k < N; k++) begin
            src_q[k] <= gat_pkg::acc_t'(weights_i.a_src[k]) * gat_pkg::acc_t'(wh_i.feat[k]);
            nbr_q[k] <= gat_pkg::acc_t'(weights_i.a_nbr[k]) * gat_pkg::acc_t'(wh_i.feat[k]);
          end
        end
      end
    end else begin : g_sum
      // Pairwise reduction of the level below
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int k = 0; k < N; k++) begin
            src_q[k] <= '0;
            nbr_q[k] <= '0;
          end
        end else begin
          for (int k = 0; k < N; k++) begin
            src_q[k] <= g_lvl[lvl-1].src_q[2*k] + g_lvl[lvl-1].src_q[2*k+1];
            nbr_q[k] <= g_lvl[lvl-1].nbr_q[2*k] + g_lvl[lvl-1].nbr_q[2*k+1];
          end
        end
      end
    end
  end

  // ==============================
  // Combine stage
  // ==============================
  // A source word scores against itself
  assign src_sel = flag_q[LVLS] ? g_lvl[LVLS].src_q[0] : src_score_q;
  assign total   = SUM_W'(src_sel) + SUM_W'(g_lvl[LVLS].nbr_q[0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_score_q <= '0;
      total_q     <= '0;
      comb_vld_q  <= 1'b0;
      comb_src_q  <= 1'b0;
    end else begin
      if (flag_q[LVLS]) begin
        src_score_q <= g_lvl[LVLS].src_q[0];
      end
      total_q    <= total >>> shift_q[LVLS];
      comb_vld_q <= vld_q[LVLS];
      comb_src_q <= flag_q[LVLS];
    end
  end

  // ==============================
  // ReLU and saturation
  // ==============================
  always_comb begin
    if (total_q[SUM_W-1]) begin
      coef_val = '0;
    end else if (total_q > COEF_MAX) begin
      coef_val = COEF_MAX[DW-1:0];
    end else begin
      coef_val = total_q[DW-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_q <= 1'b0;
      coef_q    <= '0;
    end else begin
      coef_wr_q     <= comb_vld_q;
      coef_q.is_src <= comb_src_q;
      coef_q.value  <= coef_val;
    end
  end

  assign coef_wr_o = coef_wr_q;
  assign coef_o    = coef_q;

endmodule

// ==== coef_credit_buffer.sv ====
`timescale 1ns/100ps

module coef_credit_buffer #(
  parameter int DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_i,
  input  gat_pkg::coef_word_t wr_data_i,
  input  logic                coef_credit_i,
  output logic                coef_vld_o,
  output gat_pkg::coef_word_t coef_o,
  output logic                wh_credit_o
);

  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = 16;

  gat_pkg::coef_word_t mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fill_cnt;
  logic [CRED_W-1:0] credit_cnt;
  logic              pop;

  logic                coef_vld_q;
  logic                wh_credit_q;
  gat_pkg::coef_word_t coef_q;

  // Wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==============================
  // Storage
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // Upstream credits guarantee a free slot for every write
  assign pop = (fill_cnt != '0) && (credit_cnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_i, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  // ==============================
  // Output credits
  // ==============================
  // Grant and spend in one cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({coef_credit_i, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // ==============================
  // Output register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_vld_q  <= 1'b0;
      wh_credit_q <= 1'b0;
      coef_q      <= '0;
    end else begin
      coef_vld_q  <= pop;
      // The freed slot goes straight back upstream
      wh_credit_q <= pop;
      if (pop) begin
        coef_q <= mem[rd_ptr];
      end
    end
  end

  assign coef_vld_o  = coef_vld_q;
  assign wh_credit_o = wh_credit_q;
  assign coef_o      = coef_q;

endmodule

// ==== gat_coef_top.sv ====
`timescale 1ns/100ps

module gat_coef_top #(
  parameter int COEF_FIFO_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // Configuration port
  input  logic                           cfg_we_i,
  input  logic [gat_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [gat_pkg::DATA_W-1:0]     cfg_wdata_i,
  // WH input with credit return
  input  logic                           wh_vld_i,
  input  gat_pkg::wh_word_t              wh_i,
  output logic                           wh_credit_o,
  // Coefficient output
  input  logic                           coef_credit_i,
  output logic                           coef_vld_o,
  output gat_pkg::coef_word_t            coef_o
);

  gat_pkg::attn_weights_t weights;
  logic                   coef_wr;
  gat_pkg::coef_word_t    coef_wr_data;

  // ==============================
  // Attention vector and shift
  // ==============================
  attn_weight_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .weights_o   (weights)
  );

  // ==============================
  // Score pipeline
  // ==============================
  attn_score_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_vld_i  (wh_vld_i),
    .wh_i      (wh_i),
    .weights_i (weights),
    .coef_wr_o (coef_wr),
    .coef_o    (coef_wr_data)
  );

  // ==============================
  // Output buffer
  // ==============================
  coef_credit_buffer #(
    .DEPTH (COEF_FIFO_DEPTH)
  ) u_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_i          (coef_wr),
    .wr_data_i     (coef_wr_data),
    .coef_credit_i (coef_credit_i),
    .coef_vld_o    (coef_vld_o),
    .coef_o        (coef_o),
    .wh_credit_o   (wh_credit_o)
  );

endmodule

// ==== tb_gat_coef.sv ====
`timescale 1ns/100ps

module tb_gat_coef;

  localparam int DEPTH       = 8;
  localparam int TOTAL_WORDS = 81;
  localparam int LIMIT       = TOTAL_WORDS * 40 + 2000;

  logic clk;
  logic rst_n;
  logic cfg_we_i;
  logic [gat_pkg::CFG_ADDR_W-1:0] cfg_addr_i;
  logic [gat_pkg::DATA_W-1:0] cfg_wdata_i;
  logic wh_vld_i;
  gat_pkg::wh_word_t wh_i;
  logic wh_credit_o;
  logic coef_credit_i;
  logic coef_vld_o;
  gat_pkg::coef_word_t coef_o;

  // Mirror of the weight registers and the model's source score
  gat_pkg::weight_t a_src_m [gat_pkg::NUM_FEAT];
  gat_pkg::weight_t a_nbr_m [gat_pkg::NUM_FEAT];
  logic [gat_pkg::SHIFT_W-1:0] shift_m;
  int src_score;

  gat_pkg::coef_word_t exp_q [$];
  string cur_test;
  int up_credits;
  int errors;
  int err_base;
  int n_tests;
  int cycles;
  int vld_total;
  int credit_total;
  int granted_total;
  int sent_total;

  gat_coef_top #(.COEF_FIFO_DEPTH(DEPTH)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==============================
  // Checks and reference model
  // ==============================
  task automatic check_coef(input string name, input gat_pkg::coef_word_t exp,
                            input gat_pkg::coef_word_t act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected is_src=%0b value=%0d, actual is_src=%0b value=%0d",
               name, exp.is_src, exp.value, act.is_src, act.value);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("** Error %s: expected count %0d, actual count %0d", name, exp, act);
    end
  endtask

  task automatic model_push(input gat_pkg::wh_word_t w);
    int s_self;
    int s_nbr;
    int total;
    gat_pkg::coef_word_t r;
    s_self = 0;
    s_nbr  = 0;
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      s_self += int'(a_src_m[k]) * int'(w.feat[k]);
      s_nbr  += int'(a_nbr_m[k]) * int'(w.feat[k]);
    end
    if (w.src_flag) begin
      src_score = s_self;
    end
    total    = (src_score + s_nbr) >>> shift_m;
    r.is_src = w.src_flag;
    r.value  = (total < 0) ? 8'd0 : (total > 127) ? 8'd127 : total[7:0];
    exp_q.push_back(r);
  endtask

  function automatic gat_pkg::wh_word_t const_word(input int v, input logic flag);
    gat_pkg::wh_word_t w;
    w = '0;
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      w.feat[k] = gat_pkg::wh_elem_t'(v);
    end
    w.src_flag = flag;
    return w;
  endfunction

  function automatic gat_pkg::wh_word_t rand_word(input int span, input logic flag);
    gat_pkg::wh_word_t w;
    w = const_word(0, flag);
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      w.feat[k] = gat_pkg::wh_elem_t'(int'($urandom_range(2 * span - 1, 0)) - span);
    end
    return w;
  endfunction

  // ==============================
  // Drivers start and end on a falling edge
  // ==============================
  task automatic write_cfg(input logic [gat_pkg::CFG_ADDR_W-1:0] addr,
                           input logic [gat_pkg::DATA_W-1:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  task automatic load_weights();
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      write_cfg(gat_pkg::CFG_A_SRC_BASE + gat_pkg::CFG_ADDR_W'(k), a_src_m[k]);
      write_cfg(gat_pkg::CFG_A_NBR_BASE + gat_pkg::CFG_ADDR_W'(k), a_nbr_m[k]);
    end
    write_cfg(gat_pkg::CFG_SHIFT_ADDR, gat_pkg::DATA_W'(shift_m));
  endtask

  // Upstream may only send while it holds a credit
  task automatic send_word(input gat_pkg::wh_word_t w);
    while (up_credits == 0) begin
      @(negedge clk);
    end
    wh_i     = w;
    wh_vld_i = 1'b1;
    up_credits--;
    sent_total++;
    model_push(w);
    @(negedge clk);
    wh_vld_i = 1'b0;
  endtask

  task automatic grant_credits(input int n);
    repeat (n) begin
      coef_credit_i = 1'b1;
      granted_total++;
      @(negedge clk);
    end
    coef_credit_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || up_credits != DEPTH) begin
      @(negedge clk);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = errors;
    n_tests++;
  endtask

  task automatic end_test();
    $display("Test %s %s, %0d errors", cur_test,
             (errors == err_base) ? "passed" : "failed", errors - err_base);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_idle();
    int vld_base;
    int cred_base;
    begin_test("reset_idle");
    vld_base  = vld_total;
    cred_base = credit_total;
    send_word(const_word(1, 1'b1));
    send_word(const_word(2, 1'b0));
    send_word(const_word(3, 1'b0));
    repeat (20) @(negedge clk);
    check_count(cur_test, 0, vld_total - vld_base);
    check_count(cur_test, 0, credit_total - cred_base);
    check_count(cur_test, DEPTH - 3, up_credits);
    grant_credits(3);
    drain();
    end_test();
  endtask

  task automatic test_random();
    begin_test("random");
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      a_src_m[k] = gat_pkg::weight_t'($urandom);
      a_nbr_m[k] = gat_pkg::weight_t'($urandom);
    end
    shift_m = 5'd4;
    load_weights();
    grant_credits(21);
    send_word(rand_word(8, 1'b1));
    repeat (20) send_word(rand_word(8, 1'b0));
    drain();
    end_test();
  endtask

  // Totals of 0, -48, 120, 112 and 160 with unit neighbour weights
  task automatic test_clamp();
    gat_pkg::wh_word_t ramp;
    begin_test("clamp");
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      a_src_m[k] = '0;
      a_nbr_m[k] = 8'sd1;
    end
    shift_m = '0;
    load_weights();
    ramp = const_word(0, 1'b0);
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      ramp.feat[k] = gat_pkg::wh_elem_t'(k);
    end
    grant_credits(5);
    send_word(const_word(0, 1'b1));
    send_word(const_word(-3, 1'b0));
    send_word(ramp);
    send_word(const_word(7, 1'b0));
    send_word(const_word(10, 1'b0));
    drain();
    end_test();
  endtask

  task automatic test_shift_src();
    begin_test("shift_src");
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      a_src_m[k] = 8'sd1;
      a_nbr_m[k] = 8'sd2;
    end
    shift_m = '0;
    load_weights();
    grant_credits(14);
    send_word(const_word(1, 1'b1));
    repeat (4) send_word(rand_word(8, 1'b0));
    drain();
    shift_m = 5'd3;
    write_cfg(gat_pkg::CFG_SHIFT_ADDR, 8'd3);
    repeat (4) send_word(rand_word(8, 1'b0));
    drain();
    // New source score of 48
    send_word(const_word(3, 1'b1));
    repeat (4) send_word(rand_word(8, 1'b0));
    drain();
    end_test();
  endtask

  task automatic test_backpressure();
    int vld_base;
    int cred_base;
    begin_test("backpressure");
    vld_base  = vld_total;
    cred_base = credit_total;
    repeat (DEPTH) send_word(rand_word(8, 1'b0));
    repeat (20) @(negedge clk);
    check_count(cur_test, 0, up_credits);
    check_count(cur_test, 0, vld_total - vld_base);
    for (int i = 0; i < DEPTH; i++) begin
      grant_credits(1);
      while (vld_total - vld_base < i + 1) begin
        @(negedge clk);
      end
      repeat (4) @(negedge clk);
      check_count(cur_test, i + 1, vld_total - vld_base);
    end
    drain();
    check_count(cur_test, DEPTH, credit_total - cred_base);
    end_test();
  endtask

  task automatic test_burst();
    int vld_base;
    int cred_base;
    int given;
    begin_test("burst");
    vld_base  = vld_total;
    cred_base = credit_total;
    given     = 0;
    fork
      for (int i = 0; i < 30; i++) begin
        send_word(rand_word(8, i % 10 == 0));
      end
      begin
        while (given < 30) begin
          coef_credit_i = ($urandom_range(2, 0) == 0);
          if (coef_credit_i) begin
            given++;
            granted_total++;
          end
          @(negedge clk);
        end
        coef_credit_i = 1'b0;
      end
    join
    drain();
    check_count(cur_test, 30, vld_total - vld_base);
    check_count(cur_test, 30, credit_total - cred_base);
    check_count(cur_test, DEPTH, up_credits);
    check_count(cur_test, granted_total, vld_total);
    end_test();
  endtask

  // ==============================
  // Output monitor and watchdog
  // ==============================
  always @(negedge clk) begin
    if (rst_n) begin
      cycles++;
      if (wh_credit_o) begin
        credit_total++;
        up_credits++;
      end
      if (coef_vld_o) begin
        vld_total++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Coefficient appeared in test %s with no word pending", cur_test);
        end else begin
          check_coef(cur_test, exp_q.pop_front(), coef_o);
        end
      end
    end
  end

  initial begin
    while (cycles < LIMIT) begin
      @(negedge clk);
    end
    $display("Timeout after %0d cycles, the DUT stopped delivering coefficients", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    wh_vld_i = 1'b0;
    wh_i = '0;
    coef_credit_i = 1'b0;
    for (int k = 0; k < gat_pkg::NUM_FEAT; k++) begin
      a_src_m[k] = '0;
      a_nbr_m[k] = '0;
    end
    shift_m = '0;
    src_score = 0;
    up_credits = DEPTH;
    errors = 0;
    err_base = 0;
    n_tests = 0;
    cycles = 0;
    vld_total = 0;
    credit_total = 0;
    granted_total = 0;
    sent_total = 0;
    cur_test = "reset";
    void'($urandom(32'hfdfc7408));
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_idle();
    test_random();
    test_clamp();
    test_shift_src();
    test_backpressure();
    test_burst();
    $display("Summary: %0d tests, %0d words, %0d errors", n_tests, sent_total, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
gat_pkg.sv
attn_weight_regs.sv
attn_score_pipe.sv
coef_credit_buffer.sv
gat_coef_top.sv
tb_gat_coef.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GAT coefficient testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_gat_coef -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0
